// File: Bender.yml
package:
  name: shader_core

sources:
  - files:
      - hdl/shader_pkg.sv
      - hdl/shader_imem.sv
      - hdl/shader_regfile.sv
      - hdl/shader_src.sv
      - hdl/shader_issue_queue.sv
      - hdl/shader_alu.sv
      - hdl/shader_core.sv
  - target: simulation
    files:
      - sim/shader_core_tb.sv

// File: all.f
hdl/shader_pkg.sv
hdl/shader_imem.sv
hdl/shader_regfile.sv
hdl/shader_src.sv
hdl/shader_issue_queue.sv
hdl/shader_alu.sv
hdl/shader_core.sv
sim/shader_core_tb.sv

// File: hdl/shader_alu.sv
/* ALU consumer: add, logic and shift in one cycle,
   four-step shift-add multiply, writeback strobe */

`timescale 1ns/1ps

module shader_alu (
	input  logic                clk,
	input  logic                reset,
	input  logic                empty,
	input  shader_pkg::alu_op_t head,
	output logic                pop,
	output logic                busy,
	output logic                wb_valid,
	output shader_pkg::wb_t     wb
);

	shader_pkg::alu_op_t           cur;
	logic [1:0]                    step;
	logic [4:0]                    shamt;
	logic [7:0]                    mul_byte;
	logic [shader_pkg::DATA_W-1:0] acc;
	logic [shader_pkg::DATA_W-1:0] mul_next;
	logic [shader_pkg::DATA_W-1:0] fast_result;

	assign pop      = !busy && !empty;
	assign shamt    = cur.src1[4:0];
	// one byte of src1 per step
	assign mul_byte = cur.src1[{step, 3'b000} +: 8];
	assign mul_next = acc + ((cur.src0 * shader_pkg::DATA_W'(mul_byte)) << {step, 3'b000});

	always_comb begin
		fast_result = '0;
		case (cur.sel)
			shader_pkg::SEL_ADD:
				fast_result = (cur.ctl == shader_pkg::CTL_SUB) ? cur.src0 - cur.src1
					: cur.src0 + cur.src1;
			shader_pkg::SEL_LOGIC:
				case (cur.ctl)
					shader_pkg::CTL_AND: fast_result = cur.src0 & cur.src1;
					shader_pkg::CTL_OR:  fast_result = cur.src0 | cur.src1;
					shader_pkg::CTL_XOR: fast_result = cur.src0 ^ cur.src1;
					default:             fast_result = cur.src0;
				endcase
			shader_pkg::SEL_SHIFT:
				case (cur.ctl)
					shader_pkg::CTL_SHL: fast_result = cur.src0 << shamt;
					shader_pkg::CTL_SHR: fast_result = cur.src0 >> shamt;
					shader_pkg::CTL_SRA: fast_result = $signed(cur.src0) >>> shamt;
					default: fast_result = (cur.src0 << shamt) | (cur.src0 >> (6'd32 - shamt));
				endcase
			default:
				fast_result = mul_next;
		endcase
	end

	// --------------------------------------------------
	// control
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			busy     <= 1'b0;
			wb_valid <= 1'b0;
			step     <= '0;
		end else begin
			wb_valid <= 1'b0;
			if (pop) begin
				busy <= 1'b1;
				step <= '0;
			end else if (wb_valid) begin
				busy <= 1'b0;
			end else if (busy) begin
				if (cur.sel != shader_pkg::SEL_MUL || step == 2'd3) begin
					wb_valid <= 1'b1;
				end
				step <= step + 1'b1;
			end
		end
	end

	// operand, accumulator and result
	always_ff @(posedge clk) begin
		if (pop) begin
			cur <= head;
			acc <= '0;
		end else if (busy && !wb_valid) begin
			acc     <= mul_next;
			wb.dst  <= cur.dst;
			wb.data <= fast_result;
		end
	end

endmodule

// File: hdl/shader_core.sv
/* shader core top: instruction memory, register file,
   instruction source, issue queue and ALU */

`timescale 1ns/1ps

module shader_core #(
	parameter int PC_WIDTH     = 9,
	parameter int IMEM_LATENCY = 2,
	parameter int DMEM_LATENCY = 2,
	parameter int QUEUE_DEPTH  = 4
) (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              imem_we,
	input  logic [PC_WIDTH-1:0]               imem_waddr,
	input  logic [31:0]                       imem_wdata,
	input  logic                              reg_we,
	input  logic [shader_pkg::REG_ADDR_W-1:0] reg_waddr,
	input  logic [shader_pkg::DATA_W-1:0]     reg_wdata,
	input  logic                              start,
	output logic                              busy,
	output logic                              result_valid,
	output shader_pkg::wb_t                   result
);

	// fetch
	logic                              imem_en;
	logic [PC_WIDTH-1:0]               imem_addr;
	shader_pkg::instr_t                imem_rdata;

	// operand read
	logic                              rd0_en;
	logic [shader_pkg::REG_ADDR_W-1:0] rd0_addr;
	logic [shader_pkg::DATA_W-1:0]     rd0_data;
	logic                              rd1_en;
	logic [shader_pkg::REG_ADDR_W-1:0] rd1_addr;
	logic [shader_pkg::DATA_W-1:0]     rd1_data;

	// issue and execute
	logic                              op_valid;
	logic                              op_ready;
	shader_pkg::alu_op_t               op;
	shader_pkg::alu_op_t               head;
	logic                              queue_empty;
	logic                              pop;
	logic                              alu_busy;

	shader_imem #(
		.PC_WIDTH     (PC_WIDTH),
		.IMEM_LATENCY (IMEM_LATENCY)
	) shader_imem_inst (
		.clk     (clk),
		.reset   (reset),
		.wr_en   (imem_we),
		.wr_addr (imem_waddr),
		.wr_data (imem_wdata),
		.rd_en   (imem_en),
		.rd_addr (imem_addr),
		.rd_data (imem_rdata)
	);

	// writeback goes both to the regfile and out of the core
	shader_regfile #(
		.DMEM_LATENCY (DMEM_LATENCY)
	) shader_regfile_inst (
		.clk        (clk),
		.reset      (reset),
		.host_we    (reg_we),
		.host_addr  (reg_waddr),
		.host_wdata (reg_wdata),
		.wb_valid   (result_valid),
		.wb         (result),
		.rd0_en     (rd0_en),
		.rd0_addr   (rd0_addr),
		.rd0_data   (rd0_data),
		.rd1_en     (rd1_en),
		.rd1_addr   (rd1_addr),
		.rd1_data   (rd1_data)
	);

	shader_src #(
		.PC_WIDTH     (PC_WIDTH),
		.IMEM_LATENCY (IMEM_LATENCY),
		.DMEM_LATENCY (DMEM_LATENCY)
	) shader_src_inst (
		.clk         (clk),
		.reset       (reset),
		.start       (start),
		.busy        (busy),
		.imem_en     (imem_en),
		.imem_addr   (imem_addr),
		.imem_rdata  (imem_rdata),
		.rd0_en      (rd0_en),
		.rd0_addr    (rd0_addr),
		.rd0_data    (rd0_data),
		.rd1_en      (rd1_en),
		.rd1_addr    (rd1_addr),
		.rd1_data    (rd1_data),
		.op_valid    (op_valid),
		.op          (op),
		.op_ready    (op_ready),
		.queue_empty (queue_empty),
		.alu_busy    (alu_busy)
	);

	shader_issue_queue #(
		.payload_t   (shader_pkg::alu_op_t),
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) shader_issue_queue_inst (
		.clk        (clk),
		.reset      (reset),
		.push_valid (op_valid),
		.push_data  (op),
		.push_ready (op_ready),
		.pop        (pop),
		.head       (head),
		.empty      (queue_empty)
	);

	shader_alu shader_alu_inst (
		.clk      (clk),
		.reset    (reset),
		.empty    (queue_empty),
		.head     (head),
		.pop      (pop),
		.busy     (alu_busy),
		.wb_valid (result_valid),
		.wb       (result)
	);

endmodule

// File: hdl/shader_imem.sv
/* instruction memory, host write port and pipelined fetch read */

`timescale 1ns/1ps

module shader_imem #(
	parameter int PC_WIDTH     = 9,
	parameter int IMEM_LATENCY = 2
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                wr_en,
	input  logic [PC_WIDTH-1:0] wr_addr,
	input  logic [31:0]         wr_data,
	input  logic                rd_en,
	input  logic [PC_WIDTH-1:0] rd_addr,
	output logic [31:0]         rd_data
);

	logic [31:0] mem [2**PC_WIDTH];
	logic [31:0] rd_pipe [IMEM_LATENCY];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// read pipe only moves with rd_en, so a stalled fetch holds its word
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < IMEM_LATENCY; i++) begin
				rd_pipe[i] <= '0;
			end
		end else if (rd_en) begin
			rd_pipe[0] <= mem[rd_addr];
			for (int i = 1; i < IMEM_LATENCY; i++) begin
				rd_pipe[i] <= rd_pipe[i-1];
			end
		end
	end

	assign rd_data = rd_pipe[IMEM_LATENCY-1];

endmodule

// File: hdl/shader_issue_queue.sv
/* issue queue: synchronous circular-buffer FIFO, payload set by type */

`timescale 1ns/1ps

module shader_issue_queue #(
	parameter type payload_t   = logic [7:0],
	parameter int  QUEUE_DEPTH = 4
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     push_valid,
	input  payload_t push_data,
	output logic     push_ready,
	input  logic     pop,
	output payload_t head,
	output logic     empty
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	payload_t         mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign push_ready = (count != CNT_W'(QUEUE_DEPTH));
	assign empty      = (count == '0);
	assign head       = mem[rd_ptr];
	assign do_push    = push_valid && push_ready;
	assign do_pop     = pop && !empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

endmodule

// File: hdl/shader_pkg.sv
/* shared shader core types: opcodes, instruction word layout,
   ALU operation and writeback structs, unit select and control codes */

package shader_pkg;

	localparam int REG_ADDR_W = 8;
	localparam int DATA_W     = 32;

	// instruction opcodes, unknown values behave as nop
	typedef enum logic [3:0] {
		OP_END  = 4'h0,
		OP_NOP  = 4'h1,
		OP_ALU  = 4'h2,
		OP_SYNC = 4'hf
	} opcode_t;

	// ALU unit select
	typedef enum logic [1:0] {
		SEL_ADD   = 2'd0,
		SEL_LOGIC = 2'd1,
		SEL_SHIFT = 2'd2,
		SEL_MUL   = 2'd3
	} alu_sel_t;

	// --------------------------------------------------
	// control codes per unit
	// --------------------------------------------------
	localparam logic [1:0] CTL_ADD  = 2'd0;
	localparam logic [1:0] CTL_SUB  = 2'd1;

	localparam logic [1:0] CTL_AND  = 2'd0;
	localparam logic [1:0] CTL_OR   = 2'd1;
	localparam logic [1:0] CTL_XOR  = 2'd2;
	localparam logic [1:0] CTL_PASS = 2'd3;

	localparam logic [1:0] CTL_SHL  = 2'd0;
	localparam logic [1:0] CTL_SHR  = 2'd1;
	localparam logic [1:0] CTL_SRA  = 2'd2;
	localparam logic [1:0] CTL_ROL  = 2'd3;

	// 32-bit instruction word, msb first
	typedef struct packed {
		logic [REG_ADDR_W-1:0] src1;
		logic [REG_ADDR_W-1:0] src0;
		logic [REG_ADDR_W-1:0] dst;
		logic [1:0]            ctl;
		alu_sel_t              sel;
		opcode_t               opcode;
	} instr_t;

	// issued operation, 76 bits
	typedef struct packed {
		alu_sel_t              sel;
		logic [1:0]            ctl;
		logic [REG_ADDR_W-1:0] dst;
		logic [DATA_W-1:0]     src0;
		logic [DATA_W-1:0]     src1;
	} alu_op_t;

	typedef struct packed {
		logic [REG_ADDR_W-1:0] dst;
		logic [DATA_W-1:0]     data;
	} wb_t;

endpackage

// File: hdl/shader_regfile.sv
/* 256 x 32 register file, two pipelined read ports,
   one write port shared by ALU writeback and host */

`timescale 1ns/1ps

module shader_regfile #(
	parameter int DMEM_LATENCY = 2
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                host_we,
	input  logic [shader_pkg::REG_ADDR_W-1:0]   host_addr,
	input  logic [shader_pkg::DATA_W-1:0]       host_wdata,
	input  logic                                wb_valid,
	input  shader_pkg::wb_t                     wb,
	input  logic                                rd0_en,
	input  logic [shader_pkg::REG_ADDR_W-1:0]   rd0_addr,
	output logic [shader_pkg::DATA_W-1:0]       rd0_data,
	input  logic                                rd1_en,
	input  logic [shader_pkg::REG_ADDR_W-1:0]   rd1_addr,
	output logic [shader_pkg::DATA_W-1:0]       rd1_data
);

	logic [shader_pkg::DATA_W-1:0]     mem [2**shader_pkg::REG_ADDR_W];
	logic [1:0]                        rd_en;
	logic [1:0][shader_pkg::REG_ADDR_W-1:0] rd_addr;
	logic [1:0][shader_pkg::DATA_W-1:0]     rd_q;

	// ALU writeback wins over host
	always_ff @(posedge clk) begin
		if (wb_valid) begin
			mem[wb.dst] <= wb.data;
		end else if (host_we) begin
			mem[host_addr] <= host_wdata;
		end
	end

	assign rd_en   = {rd1_en, rd0_en};
	assign rd_addr = {rd1_addr, rd0_addr};

	// --------------------------------------------------
	// read ports
	// --------------------------------------------------
	for (genvar p = 0; p < 2; p++) begin : g_rd
		logic [shader_pkg::DATA_W-1:0] pipe [DMEM_LATENCY];

		always_ff @(posedge clk) begin
			if (reset) begin
				for (int i = 0; i < DMEM_LATENCY; i++) begin
					pipe[i] <= '0;
				end
			end else if (rd_en[p]) begin
				pipe[0] <= mem[rd_addr[p]];
				for (int i = 1; i < DMEM_LATENCY; i++) begin
					pipe[i] <= pipe[i-1];
				end
			end
		end

		assign rd_q[p] = pipe[DMEM_LATENCY-1];
	end

	assign rd0_data = rd_q[0];
	assign rd1_data = rd_q[1];

endmodule

// File: hdl/shader_src.sv
/* instruction source: program counter, fetch and decode pipe,
   operand read, interlock, SYNC barrier and busy */

`timescale 1ns/1ps

module shader_src #(
	parameter int PC_WIDTH     = 9,
	parameter int IMEM_LATENCY = 2,
	parameter int DMEM_LATENCY = 2
) (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              start,
	output logic                              busy,
	output logic                              imem_en,
	output logic [PC_WIDTH-1:0]               imem_addr,
	input  shader_pkg::instr_t                imem_rdata,
	output logic                              rd0_en,
	output logic [shader_pkg::REG_ADDR_W-1:0] rd0_addr,
	input  logic [shader_pkg::DATA_W-1:0]     rd0_data,
	output logic                              rd1_en,
	output logic [shader_pkg::REG_ADDR_W-1:0] rd1_addr,
	input  logic [shader_pkg::DATA_W-1:0]     rd1_data,
	output logic                              op_valid,
	output shader_pkg::alu_op_t               op,
	input  logic                              op_ready,
	input  logic                              queue_empty,
	input  logic                              alu_busy
);

	// decode fields carried alongside the operand read
	typedef struct packed {
		logic                              valid;
		shader_pkg::alu_sel_t              sel;
		logic [1:0]                        ctl;
		logic [shader_pkg::REG_ADDR_W-1:0] dst;
	} dec_t;

	logic                    back_stall;
	logic                    front_stall;
	logic                    sync_wait;
	logic                    back_empty;
	logic                    dly_busy;
	logic [PC_WIDTH-1:0]     pc;
	logic                    pc_valid;
	logic [IMEM_LATENCY-1:0] if_valid;
	logic                    is_alu;
	logic                    is_sync;
	logic                    is_end;
	dec_t                    dec_in;
	dec_t                    dly [DMEM_LATENCY];

	// --------------------------------------------------
	// interlock
	// --------------------------------------------------
	// back-pressure freezes everything, a waiting SYNC only the front end
	assign back_stall  = op_valid && !op_ready;
	assign back_empty  = !dly_busy && !op_valid;
	assign sync_wait   = is_sync && !(queue_empty && !alu_busy && back_empty);
	assign front_stall = back_stall || sync_wait;

	always_comb begin
		dly_busy = 1'b0;
		for (int i = 0; i < DMEM_LATENCY; i++) begin
			dly_busy = dly_busy | dly[i].valid;
		end
	end

	// --------------------------------------------------
	// program counter and fetch
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			pc       <= '0;
			pc_valid <= 1'b0;
		end else if (!front_stall) begin
			if (is_end) begin
				pc       <= '0;
				pc_valid <= 1'b0;
			end else if (start && !busy) begin
				pc       <= '0;
				pc_valid <= 1'b1;
			end else begin
				pc <= pc + PC_WIDTH'(pc_valid);
			end
		end
	end

	assign imem_en   = pc_valid && !front_stall;
	assign imem_addr = pc;

	// valid pipe matching the imem read latency
	always_ff @(posedge clk) begin
		if (reset) begin
			if_valid <= '0;
		end else if (!front_stall) begin
			if (is_end) begin
				if_valid <= '0;
			end else begin
				if_valid <= IMEM_LATENCY'({pc_valid, if_valid} >> 1);
			end
		end
	end

	// --------------------------------------------------
	// decode and operand read
	// --------------------------------------------------
	always_comb begin
		is_alu  = 1'b0;
		is_sync = 1'b0;
		is_end  = 1'b0;
		if (if_valid[0]) begin
			case (imem_rdata.opcode)
				shader_pkg::OP_ALU:  is_alu  = 1'b1;
				shader_pkg::OP_SYNC: is_sync = 1'b1;
				shader_pkg::OP_END:  is_end  = 1'b1;
				default:             is_alu  = 1'b0;
			endcase
		end
	end

	assign rd0_en   = busy && !back_stall;
	assign rd0_addr = imem_rdata.src0;
	assign rd1_en   = busy && !back_stall;
	assign rd1_addr = imem_rdata.src1;

	assign dec_in.valid = is_alu;
	assign dec_in.sel   = imem_rdata.sel;
	assign dec_in.ctl   = imem_rdata.ctl;
	assign dec_in.dst   = imem_rdata.dst;

	// line up decode with regfile data
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DMEM_LATENCY; i++) begin
				dly[i] <= '0;
			end
		end else if (!back_stall) begin
			dly[0] <= dec_in;
			for (int i = 1; i < DMEM_LATENCY; i++) begin
				dly[i] <= dly[i-1];
			end
		end
	end

	// --------------------------------------------------
	// push register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			op_valid <= 1'b0;
		end else if (!back_stall) begin
			op_valid <= dly[DMEM_LATENCY-1].valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!back_stall) begin
			op.sel  <= dly[DMEM_LATENCY-1].sel;
			op.ctl  <= dly[DMEM_LATENCY-1].ctl;
			op.dst  <= dly[DMEM_LATENCY-1].dst;
			op.src0 <= rd0_data;
			op.src1 <= rd1_data;
		end
	end

	// run plus drain of queue and ALU
	assign busy = pc_valid || (|if_valid) || dly_busy || op_valid
		|| !queue_empty || alu_busy;

endmodule

// File: sim/shader_core_tb.sv
/* shader core testbench: vector file reader, host load and start,
   in-order writeback checker with busy handshake waits */

`timescale 1ns/1ps

module shader_core_tb;

	localparam int PC_WIDTH     = 9;
	localparam int IMEM_LATENCY = 2;
	localparam int DMEM_LATENCY = 2;
	localparam int QUEUE_DEPTH  = 4;
	localparam int WAIT_LIMIT   = 2000;

	logic                              clk;
	logic                              reset;
	logic                              imem_we;
	logic [PC_WIDTH-1:0]               imem_waddr;
	logic [31:0]                       imem_wdata;
	logic                              reg_we;
	logic [shader_pkg::REG_ADDR_W-1:0] reg_waddr;
	logic [shader_pkg::DATA_W-1:0]     reg_wdata;
	logic                              start;
	logic                              busy;
	logic                              result_valid;
	shader_pkg::wb_t                   result;

	// writebacks still owed by the DUT, oldest first
	shader_pkg::wb_t expected [$];
	int              error_count;
	int              check_count;
	int              test_count;
	int              errors_at_test_start;
	int              checks_at_test_start;

	shader_core #(
		.PC_WIDTH     (PC_WIDTH),
		.IMEM_LATENCY (IMEM_LATENCY),
		.DMEM_LATENCY (DMEM_LATENCY),
		.QUEUE_DEPTH  (QUEUE_DEPTH)
	) shader_core_inst (
		.clk          (clk),
		.reset        (reset),
		.imem_we      (imem_we),
		.imem_waddr   (imem_waddr),
		.imem_wdata   (imem_wdata),
		.reg_we       (reg_we),
		.reg_waddr    (reg_waddr),
		.reg_wdata    (reg_wdata),
		.start        (start),
		.busy         (busy),
		.result_valid (result_valid),
		.result       (result)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// --------------------------------------------------
	// host side tasks
	// --------------------------------------------------
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic write_imem(input logic [PC_WIDTH-1:0] addr, input logic [31:0] data);
		imem_we    = 1'b1;
		imem_waddr = addr;
		imem_wdata = data;
		next_cycle();
		imem_we    = 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		reg_we    = 1'b1;
		reg_waddr = addr;
		reg_wdata = data;
		next_cycle();
		reg_we    = 1'b0;
	endtask

	task automatic wait_busy(input logic level, output logic ok);
		int cycles;
		cycles = 0;
		while (busy !== level && cycles < WAIT_LIMIT) begin
			next_cycle();
			cycles++;
		end
		ok = (busy === level);
		assert (ok) else begin
			$display("timeout after %0d cycles waiting for busy to go to %0b",
				WAIT_LIMIT, level);
			error_count++;
		end
	endtask

	task automatic pulse_start(output logic ok);
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		wait_busy(1'b1, ok);
	endtask

	task automatic finish_test(input logic [8*32-1:0] label);
		int missing;
		missing = expected.size();
		if (missing != 0) begin
			$display("test %0s: %0d expected writebacks never arrived", label, missing);
			error_count += missing;
			expected.delete();
		end
		test_count++;
		$display("test %0s: %0d writebacks checked, %0d errors", label,
			check_count - checks_at_test_start, error_count - errors_at_test_start);
		errors_at_test_start = error_count;
		checks_at_test_start = check_count;
	endtask

	// --------------------------------------------------
	// writeback checker
	// --------------------------------------------------
	always @(negedge clk) begin : check_writeback
		shader_pkg::wb_t want;
		if (!reset && result_valid) begin
			if (expected.size() == 0) begin
				$display("unexpected writeback of %h to r%02h at %0t ns, none was expected",
					result.data, result.dst, $time);
				error_count++;
			end else begin
				want = expected.pop_front();
				check_count++;
				assert (result.dst == want.dst) else begin
					$display("[ERROR] %0t ns result.dst: expected %h, got %h",
						$time, want.dst, result.dst);
					error_count++;
				end
				assert (result.data == want.data) else begin
					$display("[ERROR] %0t ns result.data: expected %h, got %h",
						$time, want.data, result.data);
					error_count++;
				end
			end
		end
	end

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin : run
		int               fd;
		int               code;
		logic             ok;
		logic             more;
		logic [8*16-1:0]  cmd;
		logic [8*32-1:0]  label;
		logic [8*128-1:0] rest;
		logic [31:0]      a;
		logic [31:0]      b;
		shader_pkg::wb_t  want;

		reset      = 1'b1;
		imem_we    = 1'b0;
		imem_waddr = '0;
		imem_wdata = '0;
		reg_we     = 1'b0;
		reg_waddr  = '0;
		reg_wdata  = '0;
		start      = 1'b0;
		error_count          = 0;
		check_count          = 0;
		test_count           = 0;
		errors_at_test_start = 0;
		checks_at_test_start = 0;
		ok   = 1'b1;
		more = 1'b1;

		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		// core must sit idle until started
		repeat (8) begin
			next_cycle();
			assert (busy == 1'b0) else begin
				$display("[ERROR] %0t ns busy: expected 0, got %b", $time, busy);
				error_count++;
			end
			assert (result_valid == 1'b0) else begin
				$display("[ERROR] %0t ns result_valid: expected 0, got %b", $time, result_valid);
				error_count++;
			end
		end
		finish_test("reset_idle");

		fd = $fopen("sim/shader_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file sim/shader_vectors.txt");
			error_count++;
			more = 1'b0;
		end

		while (ok && more) begin
			code = $fscanf(fd, "%s", cmd);
			if (code != 1) begin
				more = 1'b0;
			end else begin
				case (cmd)
					"#": code = $fgets(rest, fd);
					"i": begin
						code = $fscanf(fd, "%h %h", a, b);
						write_imem(a[PC_WIDTH-1:0], b);
					end
					"r": begin
						code = $fscanf(fd, "%h %h", a, b);
						write_reg(a[7:0], b);
					end
					"e": begin
						code = $fscanf(fd, "%h %h", a, b);
						want.dst  = a[7:0];
						want.data = b;
						expected.push_back(want);
					end
					"s": pulse_start(ok);
					"d": begin
						code = $fscanf(fd, "%s", label);
						wait_busy(1'b0, ok);
						// a few idle cycles to catch stray writebacks
						repeat (4) next_cycle();
						finish_test(label);
					end
					default: begin
						$display("unknown command %0s in the vector file", cmd);
						error_count++;
						more = 1'b0;
					end
				endcase
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end

		$display("tests %0d, writebacks checked %0d, errors %0d",
			test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: sim/shader_vectors.txt
# one command per line, fields in hex
# i addr word / r reg data / e dst data / s start / d test_name
# add, sub and the four logic operations
r 01 12345678
r 02 0f0f1234
i 000 02011002
i 001 01021142
i 002 02011212
i 003 02011352
i 004 02011492
i 005 020115d2
i 006 00000000
e 10 214368ac
e 11 fcdabbbc
e 12 02041230
e 13 1f3f567c
e 14 1d3b444c
e 15 12345678
s
d alu_basic
# shifts incl negative sra, rotate and masked amount, multiplies with overflow
r 03 f0000001
r 04 00000004
r 05 00010003
r 06 00020005
r 08 ffffffe4
i 000 04012022
i 001 04032162
i 002 040322a2
i 003 040323e2
i 004 06052432
i 005 04012532
i 006 03032632
i 007 08012722
i 008 00000000
e 20 23456780
e 21 0f000000
e 22 ff000000
e 23 0000001f
e 24 000b000f
e 25 48d159e0
e 26 e0000001
e 27 23456780
s
d shift_mul
# seven multiplies back to back against a four deep queue
i 000 04053032
i 001 04063132
i 002 06053232
i 003 04013332
i 004 04033432
i 005 03033532
i 006 04043632
i 007 00000000
e 30 0004000c
e 31 00080014
e 32 000b000f
e 33 48d159e0
e 34 c0000004
e 35 e0000001
e 36 00000010
s
d queue_full
# dependent reads behind sync, stale values would give small results
r 40 00000000
r 41 00000000
i 000 02014002
i 001 0000000f
i 002 04404102
i 003 0000000f
i 004 04414232
i 005 00000001
i 006 00000000
e 40 214368ac
e 41 214368b0
e 42 850da2c0
s
d sync_barrier
# words after end must be squashed
i 000 02015092
i 001 00000000
i 002 02015102
i 003 01025242
e 50 1d3b444c
s
d end_squash
# new program from address 0 on a second start
i 000 02015352
i 001 01025442
i 002 00000000
e 53 1f3f567c
e 54 fcdabbbc
s
d restart
